// ==== tb.f ====
+incdir+rtl
rtl/lb_pkg.sv
rtl/lb_target_if.sv
rtl/lb_router.sv
rtl/status_regs.sv
rtl/ctrace_capture.sv
rtl/lb_subsys_top.sv
tb/lb_subsys_properties.sv
tb/tb_lb_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the local-bus subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   -f tb.f --top-module tb_lb_subsys -Mdir obj_dir

out=$(./obj_dir/Vtb_lb_subsys 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "ALL CHECKS PASSED"; then
   echo "Simulation passed"
else
   echo "Simulation failed"
   exit 1
fi

// ==== tb/tb_lb_subsys.sv ====
// ---------------------------------------
// Testbench for the local-bus subsystem
// with clock, reset, xorshift stimulus,
// reference model and read-back checks
// ---------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "lb_defs.svh"

module tb_lb_subsys;

   // Test lengths in cycles
   localparam int RESET_CYCLES    = 4;
   localparam int REG_OPS         = 400;
   localparam int LONG_RUN        = 70000;
   localparam int MAX_SEG         = 4;
   localparam int ENTRIES         = 2**`CTR_AW;
   localparam int RUN_MAX         = 2**`CTR_TW - 1;
   localparam int CAPTURE_CYCLES  = LONG_RUN + ENTRIES * MAX_SEG * 2;
   localparam int READBACK_CYCLES = ENTRIES + 8;
   localparam int TRACE_WR_OPS    = 32;
   localparam int TIMEOUT_CYCLES  = RESET_CYCLES + 16 + 2 * REG_OPS + 2 * CAPTURE_CYCLES
                                    + 3 * READBACK_CYCLES + TRACE_WR_OPS + 500;

   logic               lb_clk;
   logic               i_rst;
   logic               i_lb_valid;
   logic               i_lb_rnw;
   lb_pkg::lb_addr_t   i_lb_addr;
   lb_pkg::lb_data_t   i_lb_wdata;
   lb_pkg::lb_data_t   o_lb_rdata;
   logic               i_ctr_start;
   logic [`CTR_DW-1:0] i_ctr_data;
   logic [3:0]         o_led;

   logic [31:0]        rng = 32'd20075;
   int                 cyc = 0;
   int                 hb_count = 0;
   // Register bank model
   lb_pkg::lb_data_t   mdl_scratch;
   lb_pkg::lb_data_t   mdl_wr_count;
   logic               mdl_rd_act;
   // Trace model
   logic               mdl_busy;
   logic               mdl_done;
   int                 mdl_fill;
   int                 mdl_run;
   logic [`CTR_DW-1:0] mdl_data;
   lb_pkg::ctr_entry_t mdl_mem [ENTRIES];
   lb_pkg::lb_data_t   issue_expect;
   // Outstanding reads, oldest first
   lb_pkg::lb_data_t   exp_q [$];
   int                 due_q [$];
   bit                 entry_q [$];
   string              name_q [$];

   lb_subsys_top uut (
      .i_rst       (i_rst),
      .lb_clk      (lb_clk),
      .i_lb_valid  (i_lb_valid),
      .i_lb_rnw    (i_lb_rnw),
      .i_lb_addr   (i_lb_addr),
      .i_lb_wdata  (i_lb_wdata),
      .o_lb_rdata  (o_lb_rdata),
      .i_ctr_start (i_ctr_start),
      .i_ctr_data  (i_ctr_data),
      .o_led       (o_led)
   );

   initial lb_clk = 1'b0;
   always #50 lb_clk = ~lb_clk;

   // ---------------------------------------
   // Error reporting and compares
   // ---------------------------------------
   task automatic stop_with_failure(input string msg);
      $display("%s", msg);
      $display("CHECKS FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input lb_pkg::lb_data_t exp_v,
                             input lb_pkg::lb_data_t act_v);
      if (act_v !== exp_v) begin
         stop_with_failure($sformatf("Fail %s expected %h actual %h", name, exp_v, act_v));
      end
   endtask

   task automatic check_entry(input string name, input lb_pkg::ctr_entry_t exp_v,
                              input lb_pkg::ctr_entry_t act_v);
      if (act_v !== exp_v) begin
         stop_with_failure($sformatf("Fail %s expected run %0d data %h actual run %0d data %h",
                                     name, exp_v.run, exp_v.data, act_v.run, act_v.data));
      end
   endtask

   task automatic check_flag(input string name, input logic exp_v, input logic act_v);
      if (act_v !== exp_v) begin
         stop_with_failure($sformatf("Fail %s expected %b actual %b", name, exp_v, act_v));
      end
   endtask

   // Cycle count, heartbeat model and hang guard
   always @(posedge lb_clk) begin
      cyc = cyc + 1;
      if (!i_rst) begin
         hb_count = hb_count + 1;
      end
      if (cyc > TIMEOUT_CYCLES) begin
         stop_with_failure("Timeout: the tests did not finish within the cycle limit");
      end
   end

   // Read result lands two cycles after its strobe
   always @(negedge lb_clk) begin
      if (due_q.size() > 0 && due_q[0] == cyc) begin
         if (entry_q[0]) begin
            check_entry(name_q[0], lb_pkg::ctr_entry_t'(exp_q[0]),
                        lb_pkg::ctr_entry_t'(o_lb_rdata));
         end else begin
            check_word(name_q[0], exp_q[0], o_lb_rdata);
         end
         void'(exp_q.pop_front());
         void'(due_q.pop_front());
         void'(entry_q.pop_front());
         void'(name_q.pop_front());
      end
   end

   // ---------------------------------------
   // Models
   // ---------------------------------------
   function automatic logic [31:0] rand_next();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // Run-length rule applied to one sample
   task automatic trace_model_step(input logic start, input logic [`CTR_DW-1:0] sample);
      lb_pkg::ctr_entry_t e;
      if (start && !mdl_busy) begin
         mdl_fill = 0;
         mdl_data = sample;
         mdl_run  = 1;
         mdl_busy = 1'b1;
         mdl_done = 1'b0;
      end else if (mdl_busy) begin
         if (sample == mdl_data && mdl_run < RUN_MAX) begin
            mdl_run = mdl_run + 1;
         end else begin
            e.run  = mdl_run[`CTR_TW-1:0];
            e.data = mdl_data;
            mdl_mem[mdl_fill[`CTR_AW-1:0]] = e;
            mdl_fill = mdl_fill + 1;
            mdl_data = sample;
            mdl_run  = 1;
            // Full memory, open run dropped
            if (mdl_fill == ENTRIES) begin
               mdl_busy = 1'b0;
               mdl_done = 1'b1;
            end
         end
      end
   endtask

   function automatic lb_pkg::lb_data_t model_read(input lb_pkg::lb_addr_t addr);
      lb_pkg::lb_data_t v;
      v = '0;
      if (!addr[`LB_AW-1]) begin
         case (addr[1:0])
            2'd0:    v = `LB_ID_VALUE;
            2'd1:    v = mdl_scratch;
            2'd2:    v = mdl_wr_count;
            default: v = lb_pkg::lb_data_t'(hb_count % 2**`HB_BITS);
         endcase
      end else if (addr[`CTR_AW]) begin
         v[31]          = mdl_busy;
         v[30]          = mdl_done;
         v[`CTR_AW:0]   = mdl_fill[`CTR_AW:0];
      end else begin
         v = mdl_mem[addr[`CTR_AW-1:0]];
      end
      return v;
   endfunction

   // ---------------------------------------
   // Stimulus
   // ---------------------------------------
   // One clock of stimulus, LEDs checked against the state left by the last edge
   task automatic drive_cycle(input logic valid, input logic rnw, input lb_pkg::lb_addr_t addr,
                              input lb_pkg::lb_data_t wdata, input logic start,
                              input logic [`CTR_DW-1:0] sample);
      @(posedge lb_clk);
      #1;
      check_flag("led scratch bit", mdl_scratch[0], o_led[0]);
      check_flag("led read activity", mdl_rd_act, o_led[1]);
      check_flag("led heartbeat", hb_count[`HB_BITS-1], o_led[2]);
      check_flag("led trace done", mdl_done, o_led[3]);
      issue_expect = model_read(addr);
      i_lb_valid  = valid;
      i_lb_rnw    = rnw;
      i_lb_addr   = addr;
      i_lb_wdata  = wdata;
      i_ctr_start = start;
      i_ctr_data  = sample;
      mdl_rd_act  = valid && rnw && !addr[`LB_AW-1];
      if (valid && !rnw && !addr[`LB_AW-1]) begin
         mdl_wr_count = mdl_wr_count + 1;
         if (addr[1:0] == 2'd1) begin
            mdl_scratch = wdata;
         end
      end
      trace_model_step(start, sample);
   endtask

   task automatic bus_write(input lb_pkg::lb_addr_t addr, input lb_pkg::lb_data_t data);
      drive_cycle(1'b1, 1'b0, addr, data, 1'b0, '0);
   endtask

   task automatic issue_read(input string name, input lb_pkg::lb_addr_t addr, input bit is_entry,
                             input bit fixed, input lb_pkg::lb_data_t fixed_v);
      drive_cycle(1'b1, 1'b1, addr, '0, 1'b0, '0);
      exp_q.push_back(fixed ? fixed_v : issue_expect);
      due_q.push_back(cyc + 2);
      entry_q.push_back(is_entry);
      name_q.push_back(name);
   endtask

   task automatic drain_reads();
      while (due_q.size() > 0) begin
         drive_cycle(1'b0, 1'b0, '0, '0, 1'b0, '0);
      end
   endtask

   task automatic read_trace(input string name);
      for (int k = 0; k < ENTRIES; k++) begin
         issue_read(name, 16'h8000 | lb_pkg::lb_addr_t'(k), 1'b1, 1'b0, '0);
      end
   endtask

   // Random segments, a quarter of them repeat the last value
   task automatic run_capture(input bit restart_try, input int long_seg);
      int                 seg;
      int                 len;
      int                 cycles;
      logic [31:0]        r;
      logic [`CTR_DW-1:0] val;
      r = rand_next();
      val = r[`CTR_DW-1:0];
      drive_cycle(1'b0, 1'b0, '0, '0, 1'b1, val);
      seg = 0;
      cycles = 0;
      while (mdl_busy) begin
         r = rand_next();
         if (r[1:0] != 2'd0) begin
            val = r[31:16];
         end
         len = (seg == long_seg) ? LONG_RUN : 1 + int'(r[4:2]) % MAX_SEG;
         for (int k = 0; k < len && mdl_busy; k++) begin
            cycles = cycles + 1;
            // Extra start while busy must be ignored
            drive_cycle(1'b0, 1'b0, '0, '0, restart_try && cycles == 5, val);
         end
         seg = seg + 1;
      end
   endtask

   initial begin
      logic [31:0]      r;
      logic [31:0]      ra;
      lb_pkg::lb_addr_t a;
      i_rst        = 1'b1;
      i_lb_valid   = 1'b0;
      i_lb_rnw     = 1'b0;
      i_lb_addr    = '0;
      i_lb_wdata   = '0;
      i_ctr_start  = 1'b0;
      i_ctr_data   = '0;
      mdl_scratch  = '0;
      mdl_wr_count = '0;
      mdl_rd_act   = 1'b0;
      mdl_busy     = 1'b0;
      mdl_done     = 1'b0;
      mdl_fill     = 0;
      mdl_run      = 0;
      mdl_data     = '0;
      repeat (RESET_CYCLES) @(posedge lb_clk);
      #1;
      i_rst = 1'b0;

      // Values right after reset
      issue_read("reset id", 16'h0000, 1'b0, 1'b1, `LB_ID_VALUE);
      issue_read("reset scratch", 16'h0001, 1'b0, 1'b1, '0);
      issue_read("reset write count", 16'h0002, 1'b0, 1'b1, '0);
      issue_read("reset trace status", 16'h8040, 1'b0, 1'b1, '0);
      drain_reads();

      // Random register traffic, reads sometimes back to back
      for (int i = 0; i < REG_OPS; i++) begin
         r  = rand_next();
         ra = rand_next();
         a  = ra[15:0] & 16'h7FFF;
         case (r % 3)
            0: bus_write(a, rand_next());
            1: issue_read("register read", a, 1'b0, 1'b0, '0);
            default: begin
               issue_read("register read pair", a, 1'b0, 1'b0, '0);
               issue_read("register read pair", a ^ 16'h0001, 1'b0, 1'b0, '0);
            end
         endcase
      end
      issue_read("final scratch", 16'h0001, 1'b0, 1'b0, '0);
      issue_read("final write count", 16'h0002, 1'b0, 1'b0, '0);
      drain_reads();

      // Capture with one run past the counter limit
      run_capture(1'b0, 10);
      issue_read("status after capture", 16'h8040, 1'b0, 1'b1, 32'h4000_0040);
      read_trace("capture one entry");
      drain_reads();
      check_flag("done led after capture", 1'b1, o_led[3]);

      // Second capture with a start strobe while busy
      run_capture(1'b1, -1);
      issue_read("status after restart try", 16'h8040, 1'b0, 1'b1, 32'h4000_0040);
      read_trace("capture two entry");
      drain_reads();

      // Trace region ignores writes
      for (int i = 0; i < TRACE_WR_OPS; i++) begin
         r = rand_next();
         bus_write(16'h8000 | {9'd0, r[6:0]}, rand_next());
      end
      read_trace("entry after trace writes");
      issue_read("status after trace writes", 16'h8040, 1'b0, 1'b0, '0);
      issue_read("scratch after trace writes", 16'h0001, 1'b0, 1'b0, '0);
      issue_read("write count after trace writes", 16'h0002, 1'b0, 1'b0, '0);
      drain_reads();

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb/lb_subsys_properties.sv ====
// ---------------------------------------
// Concurrent checks on read timing, trace
// state and the done LED, bound into top
// ---------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "lb_defs.svh"

module lb_subsys_properties (
   input wire               lb_clk,
   input wire               i_rst,
   input wire               i_lb_valid,
   input wire               i_lb_rnw,
   input wire [`LB_DW-1:0]  i_lb_rdata,
   input wire [3:0]         i_led,
   input wire               i_busy,
   input wire               i_done,
   input wire [`CTR_AW:0]   i_fill
);

   // Full trace memory count
   localparam logic [`CTR_AW:0] FILL_MAX = {1'b1, {`CTR_AW{1'b0}}};

   // Read data moves only on a read return
   a_rdata_timing: assert property (@(posedge lb_clk) disable iff (i_rst)
      !$stable(i_lb_rdata) |-> $past(i_lb_valid && i_lb_rnw, 2))
      else $error("read data changed without a read strobe two cycles earlier");

   a_busy_done: assert property (@(posedge lb_clk) disable iff (i_rst)
      !(i_busy && i_done))
      else $error("trace busy and done both set");

   a_fill_max: assert property (@(posedge lb_clk) disable iff (i_rst)
      i_fill <= FILL_MAX)
      else $error("trace fill count beyond memory size");

   // Top LED mirrors trace done
   a_done_led: assert property (@(posedge lb_clk) disable iff (i_rst)
      i_led[3] == i_done)
      else $error("trace LED differs from done");

endmodule

bind lb_subsys_top lb_subsys_properties u_props (
   .lb_clk     (lb_clk),
   .i_rst      (i_rst),
   .i_lb_valid (i_lb_valid),
   .i_lb_rnw   (i_lb_rnw),
   .i_lb_rdata (o_lb_rdata),
   .i_led      (o_led),
   .i_busy     (u_ctrace.busy),
   .i_done     (u_ctrace.done),
   .i_fill     (u_ctrace.fill_q)
);

`default_nettype wire

// ==== rtl/lb_subsys_top.sv ====
// ---------------------------------------
// Local-bus subsystem top: router, status
// registers, capture trace and LED merge
// ---------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "lb_defs.svh"

module lb_subsys_top (
   input  wire               i_rst,
   input  wire               lb_clk,
   // Local bus from the Ethernet bridge
   input  wire               i_lb_valid,
   input  wire               i_lb_rnw,
   input  wire [`LB_AW-1:0]  i_lb_addr,
   input  wire [`LB_DW-1:0]  i_lb_wdata,
   output logic [`LB_DW-1:0] o_lb_rdata,
   // Debug bus capture
   input  wire               i_ctr_start,
   input  wire [`CTR_DW-1:0] i_ctr_data,
   // Board LEDs
   output logic [3:0]        o_led
);

   logic [2:0] led_regs;
   logic       ctr_done;

   // One link per target
   lb_target_if regs_bus ();
   lb_target_if trace_bus ();

   // ---------------------------------------
   // Bus routing
   // ---------------------------------------
   lb_router u_router (
      .lb_clk     (lb_clk),
      .i_rst      (i_rst),
      .i_lb_valid (i_lb_valid),
      .i_lb_rnw   (i_lb_rnw),
      .i_lb_addr  (i_lb_addr),
      .i_lb_wdata (i_lb_wdata),
      .o_lb_rdata (o_lb_rdata),
      .regs_bus   (regs_bus),
      .trace_bus  (trace_bus)
   );

   // ---------------------------------------
   // Targets
   // ---------------------------------------
   status_regs u_status_regs (
      .lb_clk     (lb_clk),
      .i_rst      (i_rst),
      .bus        (regs_bus),
      .o_led_regs (led_regs)
   );

   ctrace_capture u_ctrace (
      .lb_clk      (lb_clk),
      .i_rst       (i_rst),
      .i_ctr_start (i_ctr_start),
      .i_ctr_data  (i_ctr_data),
      .bus         (trace_bus),
      .o_ctr_done  (ctr_done)
   );

   // LED[3] trace done, LED[2:0] from the register bank
   assign o_led = {ctr_done, led_regs};

endmodule

`default_nettype wire

// ==== rtl/ctrace_capture.sv ====
// ---------------------------------------
// Run-length capture of a debug bus into
// a trace memory, with bus readback of
// entries and a status word
// ---------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "lb_defs.svh"

module ctrace_capture (
   input  wire               lb_clk,
   input  wire               i_rst,
   input  wire               i_ctr_start,
   input  wire [`CTR_DW-1:0] i_ctr_data,
   lb_target_if.target       bus,
   output logic              o_ctr_done
);

   typedef enum logic [1:0] {
      ST_IDLE = 2'd0,
      ST_BUSY = 2'd1,
      ST_DONE = 2'd2
   } ctr_state_e;

   ctr_state_e                 state_q;
   // One extra bit so a full memory reads as 64
   logic [`CTR_AW:0]           fill_q;
   logic [`CTR_DW-1:0]         data_q;
   logic [`CTR_TW-1:0]         run_q;
   lb_pkg::ctr_entry_t         mem [2**`CTR_AW];
   lb_pkg::ctr_entry_t         entry_wr;
   logic                       busy;
   logic                       done;
   logic                       start_ok;
   logic                       extend;
   logic                       flush;
   logic                       last_slot;
   lb_pkg::lb_data_t           status_word;

   assign busy = (state_q == ST_BUSY);
   assign done = (state_q == ST_DONE);

   // Start honored only outside a capture
   assign start_ok = i_ctr_start && !busy;

   // Same value and room left in the run counter
   assign extend = busy && (i_ctr_data == data_q) && (run_q != {`CTR_TW{1'b1}});
   // Anything else closes the held run
   assign flush  = busy && !extend;

   // Slot 63 being written means the memory is full after this edge
   assign last_slot = (fill_q[`CTR_AW-1:0] == {`CTR_AW{1'b1}});

   // ---------------------------------------
   // Capture FSM
   // ---------------------------------------
   always_ff @(posedge lb_clk) begin
      if (i_rst) begin
         state_q <= ST_IDLE;
         fill_q  <= '0;
         data_q  <= '0;
         run_q   <= '0;
      end else if (start_ok) begin
         // First sample taken on the start edge
         state_q <= ST_BUSY;
         fill_q  <= '0;
         data_q  <= i_ctr_data;
         run_q   <= `CTR_TW'(1);
      end else if (extend) begin
         run_q <= run_q + 1'b1;
      end else if (flush) begin
         fill_q <= fill_q + 1'b1;
         data_q <= i_ctr_data;
         run_q  <= `CTR_TW'(1);
         // Pending run is dropped once full
         if (last_slot) begin
            state_q <= ST_DONE;
         end
      end
   end

   // ---------------------------------------
   // Trace memory
   // ---------------------------------------
   always_comb begin
      entry_wr.run  = run_q;
      entry_wr.data = data_q;
   end

   always_ff @(posedge lb_clk) begin
      if (flush) begin
         mem[fill_q[`CTR_AW-1:0]] <= entry_wr;
      end
   end

   // ---------------------------------------
   // Bus readback
   // ---------------------------------------
   // busy at 31, done at 30, fill count at the bottom
   assign status_word = {busy, done, {(`LB_DW-2-(`CTR_AW+1)){1'b0}}, fill_q};

   // Address bit CTR_AW picks status over memory
   // Writes into this region have no effect
   always_ff @(posedge lb_clk) begin
      if (bus.sel_strobe && bus.rnw) begin
         if (bus.addr[`CTR_AW]) begin
            bus.rdata <= status_word;
         end else begin
            bus.rdata <= mem[bus.addr[`CTR_AW-1:0]];
         end
      end
   end

   assign o_ctr_done = done;

endmodule

`default_nettype wire

// ==== rtl/status_regs.sv ====
// ---------------------------------------
// Status register bank: ID, scratch,
// write counter, heartbeat, LED drive
// ---------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "lb_defs.svh"

module status_regs (
   input  wire         lb_clk,
   input  wire         i_rst,
   lb_target_if.target bus,
   output logic [2:0]  o_led_regs
);

   // Word addresses in the low 2 bits
   localparam logic [1:0] ADDR_ID      = 2'd0;
   localparam logic [1:0] ADDR_SCRATCH = 2'd1;
   localparam logic [1:0] ADDR_WRCNT   = 2'd2;
   localparam logic [1:0] ADDR_HB      = 2'd3;

   lb_pkg::lb_data_t     scratch_q;
   lb_pkg::lb_data_t     wr_count_q;
   logic [`HB_BITS-1:0]  hb_q;
   logic                 rd_act_q;
   lb_pkg::lb_data_t     rd_mux;
   logic                 wr_stb;
   logic                 rd_stb;

   assign wr_stb = bus.sel_strobe && !bus.rnw;
   assign rd_stb = bus.sel_strobe && bus.rnw;

   // ---------------------------------------
   // Write side
   // ---------------------------------------
   // Counter sees every write here, even to read-only words
   always_ff @(posedge lb_clk) begin
      if (i_rst) begin
         scratch_q  <= '0;
         wr_count_q <= '0;
      end else if (wr_stb) begin
         wr_count_q <= wr_count_q + 1'b1;
         if (bus.addr[1:0] == ADDR_SCRATCH) begin
            scratch_q <= bus.wdata;
         end
      end
   end

   // Free-running heartbeat, counts from reset
   always_ff @(posedge lb_clk) begin
      if (i_rst) begin
         hb_q <= '0;
      end else begin
         hb_q <= hb_q + 1'b1;
      end
   end

   // ---------------------------------------
   // Read side
   // ---------------------------------------
   always_comb begin
      case (bus.addr[1:0])
         ADDR_ID:      rd_mux = `LB_ID_VALUE;
         ADDR_SCRATCH: rd_mux = scratch_q;
         ADDR_WRCNT:   rd_mux = wr_count_q;
         ADDR_HB:      rd_mux = {{(`LB_DW-`HB_BITS){1'b0}}, hb_q};
         default:      rd_mux = '0;
      endcase
   end

   // Registered one cycle after the strobe, held otherwise
   always_ff @(posedge lb_clk) begin
      if (rd_stb) begin
         bus.rdata <= rd_mux;
      end
   end

   // One-cycle pulse after each read in this region
   always_ff @(posedge lb_clk) begin
      if (i_rst) begin
         rd_act_q <= 1'b0;
      end else begin
         rd_act_q <= rd_stb;
      end
   end

   // LED bits: heartbeat MSB, read activity, scratch bit 0
   assign o_led_regs = {hb_q[`HB_BITS-1], rd_act_q, scratch_q[0]};

endmodule

`default_nettype wire

// ==== rtl/lb_router.sv ====
// ---------------------------------------
// Local bus router: region decode, strobe
// steering and registered read-data mux
// ---------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "lb_defs.svh"

module lb_router (
   input  wire               lb_clk,
   input  wire               i_rst,
   // Host side bus
   input  wire               i_lb_valid,
   input  wire               i_lb_rnw,
   input  lb_pkg::lb_addr_t  i_lb_addr,
   input  lb_pkg::lb_data_t  i_lb_wdata,
   output lb_pkg::lb_data_t  o_lb_rdata,
   // Targets
   lb_target_if.router       regs_bus,
   lb_target_if.router       trace_bus
);

   lb_pkg::lb_region_e region;
   lb_pkg::lb_region_e rd_region_q;
   logic               rd_pend_q;

   // ---------------------------------------
   // Decode and strobe steering
   // ---------------------------------------
   // Top address bit picks the region
   assign region = lb_pkg::lb_region_e'(i_lb_addr[`LB_AW-1]);

   // Only the addressed target sees the strobe
   assign regs_bus.sel_strobe  = i_lb_valid && (region == lb_pkg::REGION_REGS);
   assign trace_bus.sel_strobe = i_lb_valid && (region == lb_pkg::REGION_TRACE);

   // Command and payload fan out to both
   assign regs_bus.rnw    = i_lb_rnw;
   assign regs_bus.addr   = i_lb_addr;
   assign regs_bus.wdata  = i_lb_wdata;
   assign trace_bus.rnw   = i_lb_rnw;
   assign trace_bus.addr  = i_lb_addr;
   assign trace_bus.wdata = i_lb_wdata;

   // ---------------------------------------
   // Read return pipeline
   // ---------------------------------------
   // Stage 1 tracks which target owns the read,
   // the target registers its data meanwhile
   always_ff @(posedge lb_clk) begin
      if (i_rst) begin
         rd_pend_q   <= 1'b0;
         rd_region_q <= lb_pkg::REGION_REGS;
      end else begin
         rd_pend_q   <= i_lb_valid && i_lb_rnw;
         rd_region_q <= region;
      end
   end

   // Stage 2 captures the owner's data, held until the next read
   always_ff @(posedge lb_clk) begin
      if (i_rst) begin
         o_lb_rdata <= '0;
      end else if (rd_pend_q) begin
         if (rd_region_q == lb_pkg::REGION_TRACE) begin
            o_lb_rdata <= trace_bus.rdata;
         end else begin
            o_lb_rdata <= regs_bus.rdata;
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/lb_target_if.sv ====
// ---------------------------------------
// Router to target link: strobe, command
// and write data out, read data back
// ---------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface lb_target_if;

   // Driven by the router
   logic             sel_strobe;
   logic             rnw;
   lb_pkg::lb_addr_t addr;
   lb_pkg::lb_data_t wdata;

   // Driven by the target, registered there
   lb_pkg::lb_data_t rdata;

   // Router side
   modport router (
      output sel_strobe,
      output rnw,
      output addr,
      output wdata,
      input  rdata
   );

   // Target side
   modport target (
      input  sel_strobe,
      input  rnw,
      input  addr,
      input  wdata,
      output rdata
   );

endinterface

`default_nettype wire

// ==== rtl/lb_pkg.sv ====
// ---------------------------------------
// Types shared by the local-bus subsystem:
// bus words, trace entry, address region
// ---------------------------------------
`default_nettype none

`include "lb_defs.svh"

package lb_pkg;

   // ---------------------------------------
   // Bus words
   // ---------------------------------------
   typedef logic [`LB_AW-1:0] lb_addr_t;
   typedef logic [`LB_DW-1:0] lb_data_t;

   // ---------------------------------------
   // Trace memory entry
   // ---------------------------------------
   // Run sits in the upper half of the bus word
   // Run is cycles the value was held, never zero
   typedef struct packed {
      logic [`CTR_TW-1:0] run;
      logic [`CTR_DW-1:0] data;
   } ctr_entry_t;

   // ---------------------------------------
   // Address regions
   // ---------------------------------------
   // Selected by the top address bit
   typedef enum logic {
      REGION_REGS  = 1'b0,
      REGION_TRACE = 1'b1
   } lb_region_e;

endpackage

`default_nettype wire

// ==== rtl/lb_defs.svh ====
// ---------------------------------------
// Shared size and constant macros for the
// local-bus subsystem: bus widths, trace
// memory geometry, ID word, heartbeat
// ---------------------------------------
`ifndef LB_DEFS_SVH
`define LB_DEFS_SVH

// Local bus address and data widths
`define LB_AW 16
`define LB_DW 32

// Trace data sample width
`define CTR_DW 16
// Run count width, max run is 2^CTR_TW - 1
`define CTR_TW 16
// Trace memory address width, 64 entries
`define CTR_AW 6

// Constant seen in the ID register
`define LB_ID_VALUE 32'h6E7E_0001

// Heartbeat counter width
// Kept small so the top bit toggles quickly in simulation
`define HB_BITS 8

`endif
